// ==== branch_unit.f ====
design/branch_pkg.sv
design/branch_decoded_if.sv
design/branch_compared_if.sv
design/comparator.sv
design/branch_decode.sv
design/branch_compare.sv
design/branch_resolve.sv
design/branch_unit.sv
sim/branch_unit_tb.sv

// ==== Makefile ====
# Verilator build and run for the branch resolution unit

VERILATOR ?= verilator
TOP       ?= branch_unit_tb
FILELIST  ?= branch_unit.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed!

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard design/*.sv) $(wildcard sim/*.sv)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the pattern file path is relative to the project root, so run from here
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/branch_patterns.txt ====
// funct3 src_a src_b pc imm pred_taken | taken mispredict illegal redirect_pc
// all fields hex, one branch per line, the last 8 lines go back to back
0 00000005 00000005 00001000 00000010 1 1 0 0 00001010
0 00000005 00000006 00001004 00000010 1 0 1 0 00001008
1 00000005 00000006 00002000 fffffff0 0 1 1 0 00001ff0
1 12345678 12345678 00002004 00000100 0 0 0 0 00002008
0 00000000 00000000 fffffff8 00000010 1 1 0 0 00000008
1 00000001 00000001 fffffffc 00000008 0 0 0 0 00000000
4 ffffffff 00000001 00003000 00000020 0 1 1 0 00003020
5 ffffffff 00000001 00003004 00000020 0 0 0 0 00003008
6 ffffffff 00000001 00003008 00000020 1 0 1 0 0000300c
7 ffffffff 00000001 0000300c 00000020 1 1 0 0 0000302c
4 00000001 ffffffff 00004000 00000040 1 0 1 0 00004004
6 00000001 ffffffff 00004004 00000040 1 1 0 0 00004044
5 80000000 7fffffff 00004008 fffffff8 1 0 1 0 0000400c
7 80000000 7fffffff 0000400c fffffff8 0 1 1 0 00004004
4 00000007 00000007 00005000 00000010 0 0 0 0 00005004
5 00000007 00000007 00005004 00000010 1 1 0 0 00005014
2 00000001 00000001 00006000 00000080 1 0 0 1 00006004
3 00000001 00000002 00006004 00000080 0 0 0 1 00006008
0 aaaa5555 aaaa5555 00007000 00000100 0 1 1 0 00007100
1 aaaa5555 5555aaaa 00007004 00000100 1 1 0 0 00007104
4 80000000 00000000 00007008 ffffff00 1 1 0 0 00006f08
6 80000000 00000000 0000700c ffffff00 1 0 1 0 00007010
2 00000000 00000000 00007010 00000004 0 0 0 1 00007014
5 00000000 ffffffff 00007014 00000008 0 1 1 0 0000701c
7 00000000 ffffffff 00007018 00000008 0 0 0 0 0000701c
0 00000000 00000001 7ffffffc 00000004 0 0 0 0 80000000

// ==== sim/branch_unit_tb.sv ====
`timescale 1ns/100ps

module branch_unit_tb;

  import branch_pkg::*;

  localparam int XLEN           = 32;
  localparam int NUM_PATTERNS   = 26;
  // words per pattern line
  localparam int FIELDS         = 10;
  // no idle gap from this pattern on
  localparam int BURST_START    = 18;
  // worst gap of 3 plus the issue cycle per pattern, plus latency and margin
  localparam int TIMEOUT_CYCLES = NUM_PATTERNS * 4 + 3 + 20;

  // one expected result and the cycle it must show up in
  typedef struct packed {
    logic            taken;
    logic            mispredict;
    logic            illegal;
    logic [XLEN-1:0] redirect_pc;
    logic [31:0]     due_cycle;
  } expect_t;

  logic            clk = 1'b0;
  logic            rst_n;
  logic            in_valid;
  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] src_a;
  logic [XLEN-1:0] src_b;
  logic [XLEN-1:0] imm;
  funct3_t         funct3;
  logic            pred_taken;
  logic            res_valid;
  logic            taken;
  logic            mispredict;
  logic            illegal;
  logic [XLEN-1:0] redirect_pc;

  logic [31:0] patterns [NUM_PATTERNS*FIELDS];
  expect_t     exp_q [$];
  expect_t     head;
  int          cycle = 0;
  int          value_errors = 0;
  int          sequence_errors = 0;

  branch_unit #(
    .XLEN (XLEN)
  ) branch_unit_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .pc          (pc),
    .src_a       (src_a),
    .src_b       (src_b),
    .imm         (imm),
    .funct3      (funct3),
    .pred_taken  (pred_taken),
    .res_valid   (res_valid),
    .taken       (taken),
    .mispredict  (mispredict),
    .illegal     (illegal),
    .redirect_pc (redirect_pc)
  );

  ////////////////////
  // clock and watchdog
  ////////////////////

  always #10 clk = ~clk;

  // cycle n starts at rising edge n
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles with %0d results outstanding", cycle, exp_q.size());
      $display("Test failures found");
      $finish;
    end
  end

  ////////////////////
  // stimulus
  ////////////////////

  // drive one pattern line and queue what it should produce
  task automatic issue_pattern(input int idx);
    int      base;
    expect_t e;
    base       = idx * FIELDS;
    in_valid   = 1'b1;
    funct3     = patterns[base][2:0];
    src_a      = patterns[base+1];
    src_b      = patterns[base+2];
    pc         = patterns[base+3];
    imm        = patterns[base+4];
    pred_taken = patterns[base+5][0];
    e.taken       = patterns[base+6][0];
    e.mispredict  = patterns[base+7][0];
    e.illegal     = patterns[base+8][0];
    e.redirect_pc = patterns[base+9];
    // DUT samples it at the next edge and shows the result 3 cycles after this one
    e.due_cycle   = 32'(cycle + 3);
    exp_q.push_back(e);
  endtask

  initial begin
    int gap;
    void'($urandom(32'h30ee));
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    pc         = '0;
    src_a      = '0;
    src_b      = '0;
    imm        = '0;
    funct3     = FUNCT3_BEQ;
    pred_taken = 1'b0;
    $readmemh("sim/branch_patterns.txt", patterns);
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;
    for (int i = 0; i < NUM_PATTERNS; i++) begin
      // random idle cycles before each pattern outside the closing burst
      gap = (i >= BURST_START) ? 0 : int'($urandom % 4);
      repeat (gap) begin
        @(posedge clk);
        #2;
        in_valid = 1'b0;
      end
      @(posedge clk);
      #2;
      issue_pattern(i);
    end
    @(posedge clk);
    #2;
    in_valid = 1'b0;
    // enough for the last item to drain
    repeat (6) @(posedge clk);
    assert (exp_q.size() == 0) else begin
      sequence_errors++;
      $display("%0d expected results never came out of the DUT", exp_q.size());
    end
    $display("Checks done: %0d value errors, %0d sequence errors",
             value_errors, sequence_errors);
    if (value_errors == 0 && sequence_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  ////////////////////
  // result checks
  ////////////////////

  task automatic check_result(input expect_t e);
    assert (cycle == int'(e.due_cycle)) else begin
      value_errors++;
      $display("Fail at %0t: result in cycle %0d, expected cycle %0d", $time, cycle, e.due_cycle);
    end
    assert (taken === e.taken) else begin
      value_errors++;
      $display("Fail at %0t: taken is %0b, expected %0b", $time, taken, e.taken);
    end
    assert (mispredict === e.mispredict) else begin
      value_errors++;
      $display("Fail at %0t: mispredict is %0b, expected %0b", $time, mispredict, e.mispredict);
    end
    assert (illegal === e.illegal) else begin
      value_errors++;
      $display("Fail at %0t: illegal is %0b, expected %0b", $time, illegal, e.illegal);
    end
    assert (redirect_pc === e.redirect_pc) else begin
      value_errors++;
      $display("Fail at %0t: redirect_pc is %h, expected %h", $time, redirect_pc, e.redirect_pc);
    end
  endtask

  // outputs settle after the rising edge and are read on the falling one
  always @(negedge clk) begin
    if (!rst_n) begin
      assert (!res_valid && !taken && !mispredict && !illegal) else begin
        value_errors++;
        $display("Fail at %0t: outputs active during reset", $time);
      end
    end else if (res_valid) begin
      assert (exp_q.size() != 0) else begin
        sequence_errors++;
        $display("Result at %0t arrived with no branch outstanding", $time);
      end
      if (exp_q.size() != 0) begin
        head = exp_q.pop_front();
        check_result(head);
      end
    end else begin
      // flags pulse only together with res_valid
      assert (!taken && !mispredict && !illegal) else begin
        value_errors++;
        $display("Fail at %0t: flags high without res_valid", $time);
      end
    end
  end

endmodule

// ==== design/branch_unit.sv ====
`timescale 1ns/100ps

// branch resolution unit, three stages
// decode -> compare -> resolve, one branch per cycle, 3 cycle latency
module branch_unit #(
  parameter int XLEN = 32
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_valid,
  input  logic [XLEN-1:0]     pc,
  input  logic [XLEN-1:0]     src_a,
  input  logic [XLEN-1:0]     src_b,
  input  logic [XLEN-1:0]     imm,
  input  branch_pkg::funct3_t funct3,
  input  logic                pred_taken,
  output logic                res_valid,
  output logic                taken,
  output logic                mispredict,
  output logic                illegal,
  output logic [XLEN-1:0]     redirect_pc
);

  // stage-to-stage links
  branch_decoded_if  #(.XLEN(XLEN)) dec_if ();
  branch_compared_if #(.XLEN(XLEN)) cmp_if ();

  ////////////////////
  // stage 1
  ////////////////////
  branch_decode #(
    .XLEN (XLEN)
  ) branch_decode_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .pc         (pc),
    .src_a      (src_a),
    .src_b      (src_b),
    .imm        (imm),
    .funct3     (funct3),
    .pred_taken (pred_taken),
    .dec        (dec_if.source)
  );

  // stage 2
  branch_compare #(
    .XLEN (XLEN)
  ) branch_compare_i (
    .clk   (clk),
    .rst_n (rst_n),
    .dec   (dec_if.sink),
    .cmp   (cmp_if.source)
  );

  // stage 3, drives the unit outputs
  branch_resolve #(
    .XLEN (XLEN)
  ) branch_resolve_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmp         (cmp_if.sink),
    .res_valid   (res_valid),
    .taken       (taken),
    .mispredict  (mispredict),
    .illegal     (illegal),
    .redirect_pc (redirect_pc)
  );

endmodule

// ==== design/branch_resolve.sv ====
`timescale 1ns/100ps

// stage 3 of the branch unit
// picks the direction, the redirect address and the mispredict flag
module branch_resolve #(
  parameter int XLEN = 32
) (
  input  logic            clk,
  input  logic            rst_n,
  branch_compared_if.sink cmp,
  output logic            res_valid,
  output logic            taken,
  output logic            mispredict,
  output logic            illegal,
  output logic [XLEN-1:0] redirect_pc
);

  logic cond;
  logic taken_d;
  logic mispredict_d;

  ////////////////////
  // resolve logic
  ////////////////////

  // flags[0] is less-than, flags[1] is equal
  // invert turns BEQ into BNE, BLT into BGE, BLTU into BGEU
  assign cond = (cmp.use_lt ? cmp.flags[0] : cmp.flags[1]) ^ cmp.invert;

  // a bad encoding never redirects
  assign taken_d = cond & ~cmp.illegal;

  // no mispredict on an illegal branch, the trap path handles it
  assign mispredict_d = (taken_d != cmp.pred_taken) & ~cmp.illegal;

  ////////////////////
  // output register
  ////////////////////

  // flags qualified by valid so they pulse with res_valid only
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_valid  <= 1'b0;
      taken      <= 1'b0;
      mispredict <= 1'b0;
      illegal    <= 1'b0;
    end else begin
      res_valid  <= cmp.valid;
      taken      <= cmp.valid & taken_d;
      mispredict <= cmp.valid & mispredict_d;
      illegal    <= cmp.valid & cmp.illegal;
    end
  end

  // target if taken, else next sequential instruction
  always_ff @(posedge clk) begin
    if (cmp.valid) begin
      redirect_pc <= taken_d ? cmp.target : cmp.fall_through;
    end
  end

endmodule

// ==== design/branch_compare.sv ====
`timescale 1ns/100ps

// stage 2 of the branch unit
// compare and both address adds run side by side
module branch_compare #(
  parameter int XLEN = 32
) (
  input  logic              clk,
  input  logic              rst_n,
  branch_decoded_if.sink    dec,
  branch_compared_if.source cmp
);

  import branch_pkg::*;

  flags_t          flags_d;
  logic [XLEN-1:0] target_d;
  logic [XLEN-1:0] fall_through_d;

  comparator #(
    .XLEN (XLEN)
  ) comparator_i (
    .a     (dec.src_a),
    .b     (dec.src_b),
    .sgnd  (dec.sgnd),
    .flags (flags_d)
  );

  // both adds wrap modulo 2**XLEN
  assign target_d       = dec.pc + dec.imm;
  assign fall_through_d = dec.pc + XLEN'(INSTR_BYTES);

  ////////////////////
  // pipeline register
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cmp.valid <= 1'b0;
    end else begin
      cmp.valid <= dec.valid;
    end
  end

  // data fields only matter while valid, so load only then
  always_ff @(posedge clk) begin
    if (dec.valid) begin
      cmp.flags        <= flags_d;
      cmp.target       <= target_d;
      cmp.fall_through <= fall_through_d;
      cmp.invert       <= dec.invert;
      cmp.use_lt       <= dec.use_lt;
      cmp.illegal      <= dec.illegal;
      cmp.pred_taken   <= dec.pred_taken;
    end
  end

endmodule

// ==== design/branch_decode.sv ====
`timescale 1ns/100ps

// stage 1 of the branch unit
// registers the operands and breaks funct3 into control bits
module branch_decode #(
  parameter int XLEN = 32
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_valid,
  input  logic [XLEN-1:0]     pc,
  input  logic [XLEN-1:0]     src_a,
  input  logic [XLEN-1:0]     src_b,
  input  logic [XLEN-1:0]     imm,
  input  branch_pkg::funct3_t funct3,
  input  logic                pred_taken,
  branch_decoded_if.source    dec
);

  import branch_pkg::*;

  logic sgnd_d;
  logic invert_d;
  logic use_lt_d;
  logic illegal_d;

  ////////////////////
  // funct3 decode
  ////////////////////

  // bit 1 clear means BLT/BGE (or BEQ/BNE, where sign does not matter)
  assign sgnd_d   = ~funct3[1];
  // BNE, BGE, BGEU take the opposite of the raw compare
  assign invert_d = funct3[0];
  // BLT family uses the less-than flag
  assign use_lt_d = funct3[2];
  // anything outside the six branch codes, i.e. 2 and 3
  assign illegal_d = !(funct3 inside {FUNCT3_BEQ, FUNCT3_BNE, FUNCT3_BLT,
                                      FUNCT3_BGE, FUNCT3_BLTU, FUNCT3_BGEU});

  ////////////////////
  // pipeline register
  ////////////////////

  // valid is the only control state here
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec.valid <= 1'b0;
    end else begin
      dec.valid <= in_valid;
    end
  end

  // payload and control bits, loaded with each item
  always_ff @(posedge clk) begin
    if (in_valid) begin
      dec.pc         <= pc;
      dec.src_a      <= src_a;
      dec.src_b      <= src_b;
      dec.imm        <= imm;
      dec.sgnd       <= sgnd_d;
      dec.invert     <= invert_d;
      dec.use_lt     <= use_lt_d;
      dec.illegal    <= illegal_d;
      dec.pred_taken <= pred_taken;
    end
  end

endmodule

// ==== design/comparator.sv ====
`timescale 1ns/100ps

// equality and less-than on two operands
// signed compare done by flipping the msb, then one unsigned compare
module comparator #(
  parameter int XLEN = 32
) (
  input  logic [XLEN-1:0]    a,
  input  logic [XLEN-1:0]    b,
  input  logic               sgnd,
  output branch_pkg::flags_t flags
);

  logic            eq;
  logic            lt;
  logic [XLEN-1:0] a_flip;
  logic [XLEN-1:0] b_flip;

  // flipping the sign bit maps two's complement order onto unsigned order
  assign a_flip = {a[XLEN-1] ^ sgnd, a[XLEN-2:0]};
  assign b_flip = {b[XLEN-1] ^ sgnd, b[XLEN-2:0]};

  // equality is the same for both, so raw operands
  assign eq = (a == b);
  assign lt = (a_flip < b_flip);

  // high bit equal, low bit less-than
  assign flags = {eq, lt};

endmodule

// ==== design/branch_compared_if.sv ====
`timescale 1ns/100ps

// compare results, compare stage -> resolve stage
interface branch_compared_if #(
  parameter int XLEN = 32
);

  logic               valid;
  // {equal, less-than} of src_a against src_b
  branch_pkg::flags_t flags;
  // control bits carried along from decode
  logic               invert;
  logic               use_lt;
  logic               illegal;
  logic               pred_taken;
  // both candidate next addresses, picked in resolve
  logic [XLEN-1:0]    target;
  logic [XLEN-1:0]    fall_through;

  modport source (
    output valid, flags, invert, use_lt, illegal, pred_taken,
    output target, fall_through
  );

  modport sink (
    input valid, flags, invert, use_lt, illegal, pred_taken,
    input target, fall_through
  );

endinterface

// ==== design/branch_decoded_if.sv ====
`timescale 1ns/100ps

// decoded branch, decode stage -> compare stage
interface branch_decoded_if #(
  parameter int XLEN = 32
);

  // item strobe, no back-pressure
  logic            valid;
  // branch address and the two register operands
  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] src_a;
  logic [XLEN-1:0] src_b;
  // sign-extended B-type immediate
  logic [XLEN-1:0] imm;
  // control bits from funct3
  logic            sgnd;
  logic            invert;
  logic            use_lt;
  logic            illegal;
  // direction guessed by the front end
  logic            pred_taken;

  modport source (
    output valid, pc, src_a, src_b, imm,
    output sgnd, invert, use_lt, illegal, pred_taken
  );

  modport sink (
    input valid, pc, src_a, src_b, imm,
    input sgnd, invert, use_lt, illegal, pred_taken
  );

endinterface

// ==== design/branch_pkg.sv ====
package branch_pkg;

  ////////////////////
  // shared vector types
  ////////////////////

  // funct3 field of a conditional branch, instr[14:12]
  typedef logic [2:0] funct3_t;

  // comparator result, {equal, less-than}
  typedef logic [1:0] flags_t;

  ////////////////////
  // branch funct3 codes
  ////////////////////

  // bit 0 inverts the condition, bit 1 selects unsigned,
  // bit 2 selects less-than over equality
  localparam funct3_t FUNCT3_BEQ  = 3'd0;
  localparam funct3_t FUNCT3_BNE  = 3'd1;
  localparam funct3_t FUNCT3_BLT  = 3'd4;
  localparam funct3_t FUNCT3_BGE  = 3'd5;
  localparam funct3_t FUNCT3_BLTU = 3'd6;
  localparam funct3_t FUNCT3_BGEU = 3'd7;
  // codes 2 and 3 have no branch behind them

  ////////////////////
  // instruction size
  ////////////////////

  // no compressed instructions, so fall-through is always pc + 4
  localparam int INSTR_BYTES = 4;

endpackage
